// ==== banked_xbar_mem.f ====
source/xbar_mem_pkg.sv
source/bank_req_if.sv
source/bank_arbiter.sv
source/xbar_request_stage.sv
source/xbar_bank_stage.sv
source/banked_xbar_mem.sv
sim/banked_xbar_mem_checker.sv
sim/banked_xbar_mem_props.sv
sim/banked_xbar_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, output goes to sim.log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module banked_xbar_mem_tb -o banked_xbar_mem_sim \
  -f banked_xbar_mem.f
./obj_dir/banked_xbar_mem_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^Verification passed$" sim.log
then
  echo "run_sim: PASS"
  exit 0
fi
echo "run_sim: FAIL, see sim.log"
exit 1

// ==== sim/banked_xbar_mem_cases.txt ====
// test port write addr data mask expected_read, all hex
// one test's lines start together, a port's own lines run in order
01 0 1 05 11223344 f 00000000
01 0 0 05 00000000 0 11223344
02 1 1 4a a5a5a5a5 f 00000000
02 1 1 4a 12345678 5 00000000
02 1 0 4a 00000000 0 a534a578
03 0 1 81 20000001 f 00000000
03 1 1 c2 30000002 f 00000000
03 2 1 03 00000003 f 00000000
03 3 1 44 10000004 f 00000000
03 0 0 81 00000000 0 20000001
03 1 0 c2 00000000 0 30000002
03 2 0 03 00000000 0 00000003
03 3 0 44 00000000 0 10000004
04 0 0 c2 00000000 0 30000002
04 1 0 c2 00000000 0 30000002
04 2 0 c2 00000000 0 30000002
04 3 0 c2 00000000 0 30000002
05 0 0 05 00000000 0 11223344
05 1 1 05 55667788 f 00000000
05 2 0 05 00000000 0 55667788
05 3 0 05 00000000 0 11223344
06 2 0 03 00000000 0 00000003
06 2 0 05 00000000 0 55667788
06 2 0 44 00000000 0 10000004

// ==== sim/banked_xbar_mem_checker.sv ====
//----------------------------------------------------------
// samples the DUT ports at each rising edge
// predicts yumi_o from a round robin model per bank
// read data is expected exactly one edge after acceptance
//----------------------------------------------------------
`timescale 1ns/1ps

module banked_xbar_mem_checker
  import xbar_mem_pkg::*;
#(
  parameter int NUM_PORTS = 4
)
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [NUM_PORTS-1:0]             req_v_i,
  input  logic [NUM_PORTS-1:0]             req_w_i,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0] req_addr_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] exp_data_i,
  input  logic [NUM_PORTS-1:0]             yumi_i,
  input  logic [NUM_PORTS-1:0]             rsp_v_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] rsp_data_i,
  output int                               chk_cnt_o,
  output int                               err_cnt_o
);

  int                last_port [NUM_BANKS];
  int                due_port [$];
  logic [DATA_W-1:0] due_data [$];

  task automatic compare_returns();
    logic [NUM_PORTS-1:0]             exp_v;
    logic [NUM_PORTS-1:0][DATA_W-1:0] exp_d;
    int                               p;
    exp_v = '0;
    exp_d = '0;
    while (due_port.size() > 0)
    begin
      p        = due_port.pop_front();
      exp_v[p] = 1'b1;
      exp_d[p] = due_data.pop_front();
    end
    chk_cnt_o++;
    if (rsp_v_i !== exp_v)
    begin
      $display("ERR %0t v_o expected %b got %b", $time, exp_v, rsp_v_i);
      err_cnt_o++;
    end
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (exp_v[i])
      begin
        chk_cnt_o++;
        if (rsp_data_i[i] !== exp_d[i])
        begin
          $display("ERR %0t data_o[%0d] expected %h got %h", $time, i, exp_d[i],
                   rsp_data_i[i]);
          err_cnt_o++;
        end
      end
    end
  endtask

  task automatic compare_grants();
    logic [NUM_PORTS-1:0] want;
    logic [NUM_PORTS-1:0] exp_yumi;
    int                   idx;
    int                   pick;
    exp_yumi = '0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      want = '0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (req_v_i[p] && int'(req_addr_i[p][ADDR_W-1 -: BANK_W]) == b)
          want[p] = 1'b1;
      end
      // first requester after the last granted port, wrapping
      pick = -1;
      for (int i = 1; i <= NUM_PORTS; i++)
      begin
        idx = (last_port[b] + i) % NUM_PORTS;
        if (pick < 0 && want[idx])
          pick = idx;
      end
      if (pick >= 0)
      begin
        exp_yumi[pick] = 1'b1;
        last_port[b]   = pick;
      end
    end
    chk_cnt_o++;
    if (yumi_i !== exp_yumi)
    begin
      $display("ERR %0t yumi_o expected %b got %b", $time, exp_yumi, yumi_i);
      err_cnt_o++;
    end
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (req_v_i[p] && yumi_i[p] && !req_w_i[p])
      begin
        due_port.push_back(p);
        due_data.push_back(exp_data_i[p]);
      end
    end
  endtask

  always @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int b = 0; b < NUM_BANKS; b++)
        last_port[b] = NUM_PORTS - 1;
      due_port.delete();
      due_data.delete();
      chk_cnt_o = 0;
      err_cnt_o = 0;
    end
    else
    begin
      // returns first, they belong to the previous edge
      compare_returns();
      compare_grants();
    end
  end

endmodule

// ==== sim/banked_xbar_mem_props.sv ====
//----------------------------------------------------------
// checks on the registered bank grants and v_o
// bound into every xbar_bank_stage instance
//----------------------------------------------------------
`timescale 1ns/1ps

module banked_xbar_mem_props
  import xbar_mem_pkg::*;
#(
  parameter int NUM_PORTS = 4
)
(
  input logic                                clk_i,
  input logic                                arst_n_i,
  input logic [NUM_BANKS-1:0][NUM_PORTS-1:0] grant_i,
  input logic [NUM_PORTS-1:0]                ret_v_i
);

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    a_grant_oh: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(grant_i[b])) else $error("bank %0d grant is not one-hot", b);
  end

  // a port is owned by at most one bank
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port
    logic [NUM_BANKS-1:0] owners;
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_col
      assign owners[b] = grant_i[b][p];
    end
    a_one_owner: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(owners)) else $error("port %0d granted by two banks", p);
  end

  a_quiet_reset: assert property (@(posedge clk_i) !arst_n_i |-> ret_v_i == '0)
    else $error("v_o active during reset");

endmodule

bind xbar_bank_stage banked_xbar_mem_props #(.NUM_PORTS(NUM_PORTS)) u_props (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .grant_i  (grant_r),
  .ret_v_i  (v_o)
);

// ==== sim/banked_xbar_mem_tb.sv ====
//----------------------------------------------------------
// four ports under round robin with stimulus from the cases file
// a port's lines in one test are issued back to back
//----------------------------------------------------------
`timescale 1ns/1ps

module banked_xbar_mem_tb
  import xbar_mem_pkg::*;
();

  localparam int NUM_PORTS  = 4;
  localparam int CASE_COLS  = 7;
  localparam int MAX_LINES  = 64;
  localparam int WAIT_LIMIT = 16;

  logic                             clk_i;
  logic                             arst_n_i;
  logic [NUM_PORTS-1:0]             req_v;
  logic [NUM_PORTS-1:0]             req_w;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] req_addr;
  logic [NUM_PORTS-1:0][DATA_W-1:0] req_data;
  logic [NUM_PORTS-1:0][MASK_W-1:0] req_mask;
  logic [NUM_PORTS-1:0][DATA_W-1:0] exp_data;
  logic [NUM_PORTS-1:0]             yumi;
  logic [NUM_PORTS-1:0]             rsp_v;
  logic [NUM_PORTS-1:0][DATA_W-1:0] rsp_data;
  int                               chk_cnt;
  int                               err_cnt;
  logic [31:0]                      case_mem [CASE_COLS*MAX_LINES];
  bit                               issued [MAX_LINES];
  logic [31:0]                      lfsr_q;
  int                               fail_cnt;
  int                               test_cnt;

  always #4 clk_i = ~clk_i;

  banked_xbar_mem #(.NUM_PORTS(NUM_PORTS), .ARB_POLICY(ARB_ROUND_ROBIN)) dut0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (req_v),
    .w_i      (req_w),
    .addr_i   (req_addr),
    .data_i   (req_data),
    .mask_i   (req_mask),
    .yumi_o   (yumi),
    .v_o      (rsp_v),
    .data_o   (rsp_data)
  );

  banked_xbar_mem_checker #(.NUM_PORTS(NUM_PORTS)) u_chk (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_v_i    (req_v),
    .req_w_i    (req_w),
    .req_addr_i (req_addr),
    .exp_data_i (exp_data),
    .yumi_i     (yumi),
    .rsp_v_i    (rsp_v),
    .rsp_data_i (rsp_data),
    .chk_cnt_o  (chk_cnt),
    .err_cnt_o  (err_cnt)
  );

  // right shifting galois step
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hd000_0001;
    return s >> 1;
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    for (int i = 0; i < 3; i++)
    begin
      gap = (gap << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // first line of this test for port p that is not yet issued
  function automatic int next_line(input int p, input int first, input int last);
    int found;
    found = -1;
    for (int l = first; l < last; l++)
    begin
      if (found < 0 && !issued[l] && case_mem[l*CASE_COLS+1] == p)
        found = l;
    end
    return found;
  endfunction

  task automatic drive_port(input int p, input int l);
    int base;
    base        = l * CASE_COLS;
    req_v[p]    = 1'b1;
    req_w[p]    = case_mem[base+2][0];
    req_addr[p] = case_mem[base+3][ADDR_W-1:0];
    req_data[p] = case_mem[base+4];
    req_mask[p] = case_mem[base+5][MASK_W-1:0];
    exp_data[p] = case_mem[base+6];
    issued[l]   = 1'b1;
  endtask

  task automatic run_test(input int first, input int last);
    int                   wait_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0] taken;
    int                   l;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      wait_cnt[p] = 0;
      l = next_line(p, first, last);
      if (l >= 0)
        drive_port(p, l);
    end
    while (req_v != '0 && fail_cnt == 0)
    begin
      @(posedge clk_i);
      taken = req_v & yumi;
      @(negedge clk_i);
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (taken[p])
        begin
          req_v[p]    = 1'b0;
          wait_cnt[p] = 0;
          l = next_line(p, first, last);
          if (l >= 0)
            drive_port(p, l);
        end
        else if (req_v[p])
        begin
          wait_cnt[p]++;
          if (wait_cnt[p] > WAIT_LIMIT)
          begin
            $display("timeout: port %0d saw no yumi_o within %0d cycles", p, WAIT_LIMIT);
            fail_cnt++;
            req_v = '0;
          end
        end
      end
    end
    // last read comes back on this edge
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  initial
  begin
    int line_idx;
    int first;
    int gap;
    logic [31:0] test_id;
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    // reads pending through reset must not reach v_o
    req_v    = '1;
    req_w    = '0;
    req_addr = '0;
    req_data = '0;
    req_mask = '0;
    exp_data = '0;
    lfsr_q   = 32'h34f0;
    fail_cnt = 0;
    test_cnt = 0;
    for (int i = 0; i < CASE_COLS * MAX_LINES; i++)
      case_mem[i] = 32'hffff_ffff;
    $readmemh("sim/banked_xbar_mem_cases.txt", case_mem);
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    req_v    = '0;
    line_idx = 0;
    while (line_idx < MAX_LINES && case_mem[line_idx*CASE_COLS] != 32'hffff_ffff
           && fail_cnt == 0)
    begin
      test_id = case_mem[line_idx*CASE_COLS];
      first   = line_idx;
      while (line_idx < MAX_LINES && case_mem[line_idx*CASE_COLS] == test_id)
        line_idx++;
      run_test(first, line_idx);
      test_cnt++;
      $display("test %0d done, %0d lines, %0d errors so far", test_id,
               line_idx - first, err_cnt + fail_cnt);
      draw_gap(gap);
      repeat (gap) @(negedge clk_i);
    end
    if (test_cnt == 0)
    begin
      $display("no test lines could be read from the cases file");
      fail_cnt++;
    end
    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt,
             err_cnt + fail_cnt);
    if (err_cnt + fail_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== source/bank_arbiter.sv ====
//----------------------------------------------------------
// single bank arbiter, grant is combinational from reqs_i
// round robin pointer only exists in the round robin build
// after reset port 0 has the highest priority
//----------------------------------------------------------
`timescale 1ns/1ps

module bank_arbiter
  import xbar_mem_pkg::*;
#(
  parameter int          NUM_PORTS  = 4,
  parameter arb_policy_e ARB_POLICY = ARB_ROUND_ROBIN
)
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NUM_PORTS-1:0] reqs_i,
  output logic [NUM_PORTS-1:0] grant_o
);

  localparam int PTR_W = $clog2(NUM_PORTS);

  if (ARB_POLICY == ARB_ROUND_ROBIN)
  begin : g_rr
    logic [PTR_W-1:0] last_r;
    logic [PTR_W-1:0] next_idx;
    logic             found;
    int               idx;

    // search starts one past the last granted port and wraps
    always_comb
    begin
      grant_o  = '0;
      next_idx = last_r;
      found    = 1'b0;
      idx      = 0;
      for (int i = 1; i <= NUM_PORTS; i++)
      begin
        idx = int'(last_r) + i;
        if (idx >= NUM_PORTS)
        begin
          idx = idx - NUM_PORTS;
        end
        if (!found && reqs_i[idx])
        begin
          found        = 1'b1;
          grant_o[idx] = 1'b1;
          next_idx     = PTR_W'(idx);
        end
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        last_r <= PTR_W'(NUM_PORTS - 1);
      else if (found)
        last_r <= next_idx;
    end
  end
  else
  begin : g_fixed
    // isolate the lowest set request bit
    assign grant_o = reqs_i & (~reqs_i + NUM_PORTS'(1));
  end

endmodule

// ==== source/bank_req_if.sv ====
//----------------------------------------------------------
// one routed request per bank, valid for a single cycle
// grant is one-hot over the ports, all zero when idle
//----------------------------------------------------------
`timescale 1ns/1ps

interface bank_req_if
  import xbar_mem_pkg::*;
#(
  parameter int NUM_PORTS = 4
);

  logic                 bank_v;
  logic                 bank_w;
  logic [OFFSET_W-1:0]  bank_offset;
  logic [DATA_W-1:0]    bank_data;
  logic [MASK_W-1:0]    bank_mask;
  logic [NUM_PORTS-1:0] bank_grant_oh;

  // request stage side
  modport req_src (
    output bank_v, bank_w, bank_offset, bank_data, bank_mask, bank_grant_oh
  );

  // bank stage side
  modport bank_dst (
    input bank_v, bank_w, bank_offset, bank_data, bank_mask, bank_grant_oh
  );

endinterface

// ==== source/banked_xbar_mem.sv ====
//----------------------------------------------------------
// banked scratchpad with a valid/yumi request handshake
// no back-pressure on v_o, the requester must take it
// NUM_PORTS from 2 to 8, four banks of 64 words
//----------------------------------------------------------
`timescale 1ns/1ps

module banked_xbar_mem
  import xbar_mem_pkg::*;
#(
  parameter int          NUM_PORTS  = 4,
  parameter arb_policy_e ARB_POLICY = ARB_ROUND_ROBIN
)
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [NUM_PORTS-1:0]             v_i,
  input  logic [NUM_PORTS-1:0]             w_i,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0] addr_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] data_i,
  input  logic [NUM_PORTS-1:0][MASK_W-1:0] mask_i,
  output logic [NUM_PORTS-1:0]             yumi_o,
  output logic [NUM_PORTS-1:0]             v_o,
  output logic [NUM_PORTS-1:0][DATA_W-1:0] data_o
);

  xbar_addr_u [NUM_PORTS-1:0] addr_u;

  // flat word address into the bank/offset view
  assign addr_u = addr_i;

  bank_req_if #(.NUM_PORTS(NUM_PORTS)) bank_bus [NUM_BANKS] ();

  xbar_request_stage #(
    .NUM_PORTS  (NUM_PORTS),
    .ARB_POLICY (ARB_POLICY)
  ) u_req (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .w_i      (w_i),
    .addr_i   (addr_u),
    .data_i   (data_i),
    .mask_i   (mask_i),
    .yumi_o   (yumi_o),
    .bank_o   (bank_bus)
  );

  xbar_bank_stage #(
    .NUM_PORTS (NUM_PORTS)
  ) u_bank (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bank_i   (bank_bus),
    .v_o      (v_o),
    .data_o   (data_o)
  );

endmodule

// ==== source/xbar_bank_stage.sv ====
//----------------------------------------------------------
// byte masked single port bank RAMs and the return path
// read data shows up the cycle after the request edge
// RAM contents are undefined until written
//----------------------------------------------------------
`timescale 1ns/1ps

module xbar_bank_stage
  import xbar_mem_pkg::*;
#(
  parameter int NUM_PORTS = 4
)
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  bank_req_if.bank_dst                     bank_i [NUM_BANKS],
  output logic [NUM_PORTS-1:0]             v_o,
  output logic [NUM_PORTS-1:0][DATA_W-1:0] data_o
);

  // flattened view of the incoming bundles
  logic [NUM_BANKS-1:0][NUM_PORTS-1:0] grant_in;
  logic [NUM_BANKS-1:0]                rd_in;

  // registered grant and read flag per bank
  logic [NUM_BANKS-1:0][NUM_PORTS-1:0] grant_r;
  logic [NUM_BANKS-1:0]                rd_v_r;

  logic [NUM_BANKS-1:0][DATA_W-1:0]    bank_rdata;

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    logic [MASK_W-1:0][7:0] mem [BANK_DEPTH];
    logic [MASK_W-1:0][7:0] wdata;
    logic [DATA_W-1:0]      rd_data_r;

    assign wdata       = bank_i[b].bank_data;
    assign grant_in[b] = bank_i[b].bank_grant_oh;
    assign rd_in[b]    = bank_i[b].bank_v & ~bank_i[b].bank_w;

    // write lanes with their mask bit set, otherwise read
    always_ff @(posedge clk_i)
    begin
      if (bank_i[b].bank_v)
      begin
        if (bank_i[b].bank_w)
        begin
          for (int k = 0; k < MASK_W; k++)
          begin
            if (bank_i[b].bank_mask[k])
              mem[bank_i[b].bank_offset][k] <= wdata[k];
          end
        end
        else
        begin
          rd_data_r <= mem[bank_i[b].bank_offset];
        end
      end
    end

    assign bank_rdata[b] = rd_data_r;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      grant_r <= '0;
      rd_v_r  <= '0;
    end
    else
    begin
      grant_r <= grant_in;
      rd_v_r  <= rd_in;
    end
  end

  // return crossbar, at most one bank names a given port
  always_comb
  begin
    v_o    = '0;
    data_o = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        v_o[p]    |= rd_v_r[b] & grant_r[b][p];
        data_o[p] |= {DATA_W{rd_v_r[b] & grant_r[b][p]}} & bank_rdata[b];
      end
    end
  end

endmodule

// ==== source/xbar_mem_pkg.sv ====
//----------------------------------------------------------
// widths and bank geometry shared by the whole memory
// bank count is fixed at four and must stay a power of two
// address is a word address, bank in the high bits
//----------------------------------------------------------

package xbar_mem_pkg;

  localparam int DATA_W     = 32;
  localparam int MASK_W     = DATA_W / 8;
  localparam int BANK_W     = 2;
  localparam int NUM_BANKS  = 1 << BANK_W;
  localparam int OFFSET_W   = 6;
  localparam int BANK_DEPTH = 1 << OFFSET_W;
  localparam int ADDR_W     = BANK_W + OFFSET_W;

  // split view of a word address
  typedef struct packed {
    logic [BANK_W-1:0]   bank;
    logic [OFFSET_W-1:0] offset;
  } xbar_addr_s;

  // ports see the flat word, the decoder sees bank and offset
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    xbar_addr_s        fields;
  } xbar_addr_u;

  typedef enum logic {
    ARB_FIXED_LO,
    ARB_ROUND_ROBIN
  } arb_policy_e;

endpackage

// ==== source/xbar_request_stage.sv ====
//----------------------------------------------------------
// decode, per bank arbitration and request steering
// fully combinational apart from the arbiter pointers
// requests must stay stable until yumi_o is seen
//----------------------------------------------------------
`timescale 1ns/1ps

module xbar_request_stage
  import xbar_mem_pkg::*;
#(
  parameter int          NUM_PORTS  = 4,
  parameter arb_policy_e ARB_POLICY = ARB_ROUND_ROBIN
)
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [NUM_PORTS-1:0]             v_i,
  input  logic [NUM_PORTS-1:0]             w_i,
  input  xbar_addr_u [NUM_PORTS-1:0]       addr_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] data_i,
  input  logic [NUM_PORTS-1:0][MASK_W-1:0] mask_i,
  output logic [NUM_PORTS-1:0]             yumi_o,
  bank_req_if.req_src                      bank_o [NUM_BANKS]
);

  // port by bank, then bank by port after the transpose
  logic [NUM_PORTS-1:0][NUM_BANKS-1:0] port_reqs;
  logic [NUM_PORTS-1:0][NUM_BANKS-1:0] port_grants;
  logic [NUM_BANKS-1:0][NUM_PORTS-1:0] bank_reqs;
  logic [NUM_BANKS-1:0][NUM_PORTS-1:0] bank_grants;

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_port
    assign port_reqs[p] = v_i[p] ? (NUM_BANKS'(1) << addr_i[p].fields.bank) : '0;

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_xpose
      assign bank_reqs[b][p]   = port_reqs[p][b];
      assign port_grants[p][b] = bank_grants[b][p];
    end

    // a port is taken when any bank picked it
    assign yumi_o[p] = |port_grants[p];
  end

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    logic [OFFSET_W-1:0] sel_offset;
    logic [DATA_W-1:0]   sel_data;
    logic [MASK_W-1:0]   sel_mask;
    logic                sel_w;

    bank_arbiter #(
      .NUM_PORTS  (NUM_PORTS),
      .ARB_POLICY (ARB_POLICY)
    ) u_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .reqs_i   (bank_reqs[b]),
      .grant_o  (bank_grants[b])
    );

    // and-or mux, the grant is one-hot
    always_comb
    begin
      sel_offset = '0;
      sel_data   = '0;
      sel_mask   = '0;
      sel_w      = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        sel_offset |= {OFFSET_W{bank_grants[b][p]}} & addr_i[p].fields.offset;
        sel_data   |= {DATA_W{bank_grants[b][p]}} & data_i[p];
        sel_mask   |= {MASK_W{bank_grants[b][p]}} & mask_i[p];
        sel_w      |= bank_grants[b][p] & w_i[p];
      end
    end

    assign bank_o[b].bank_v        = |bank_grants[b];
    assign bank_o[b].bank_w        = sel_w;
    assign bank_o[b].bank_offset   = sel_offset;
    assign bank_o[b].bank_data     = sel_data;
    assign bank_o[b].bank_mask     = sel_mask;
    assign bank_o[b].bank_grant_oh = bank_grants[b];
  end

endmodule
